/* include/vuart_defines.svh */
// word addresses on a 12-bit CSR bus; every block runs on the single clk_csr domain
`ifndef VUART_DEFINES_SVH
`define VUART_DEFINES_SVH

// address map
`define VUART_UART_BASE        12'h200
`define VUART_UNMAPPED_BASE    12'h400   // reads as zero from here up

// dfh register offsets
`define VUART_DFH_HDR_OFS      12'h000
`define VUART_DFH_MSG_ADDR_OFS 12'h008
`define VUART_DFH_MSG_DATA_OFS 12'h010
`define VUART_DFH_SCRATCH_OFS  12'h018

// uart register offsets, relative to the uart base
`define VUART_UART_TXDATA_OFS  12'h000
`define VUART_UART_RXDATA_OFS  12'h004
`define VUART_UART_STATUS_OFS  12'h008
`define VUART_UART_CTRL_OFS    12'h00c
`define VUART_UART_BAUD_OFS    12'h010

// constants and reset values
`define VUART_DFH_HEADER       32'h3000_0024
`define VUART_BAUD_DIV_RESET   16'd16
`define VUART_MSG_DATA_RESET   32'h0000_0005

`endif

/* src/vuart_pkg.sv */
// fixed widths only; the CSR bus carries one read or write strobe per cycle
package vuart_pkg;

   typedef logic [11:0] csr_addr_t;   // word address
   typedef logic [31:0] csr_data_t;
   typedef logic [19:0] msg_addr_t;
   typedef logic [7:0]  uart_byte_t;
   typedef logic [15:0] baud_div_t;   // clocks per bit

   // --------------------
   // bus and message
   // --------------------
   typedef struct packed {
      logic      rd;      // one-cycle strobes
      logic      wr;
      csr_addr_t addr;
      csr_data_t wdata;
   } csr_req_t;

   typedef struct packed {
      logic      valid;   // pulse
      csr_data_t rdata;
   } csr_rsp_t;

   typedef struct packed {
      logic      req;     // level, held until ack
      msg_addr_t addr;
      csr_data_t data;
   } irq_msg_t;

   // serial state machines
   typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_e;
   typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

endpackage

/* src/vuart_csr_decode.sv */
// adds one request stage; writes at 0x400 and above are dropped and their reads return zero
`include "vuart_defines.svh"

module vuart_csr_decode (
   input  logic                clk_csr,
   input  logic                rst_n_csr,
   input  vuart_pkg::csr_req_t csr_req,
   output vuart_pkg::csr_rsp_t csr_rsp,
   output vuart_pkg::csr_req_t dfh_req,
   output vuart_pkg::csr_req_t uart_req,
   input  vuart_pkg::csr_rsp_t dfh_rsp,
   input  vuart_pkg::csr_rsp_t uart_rsp
);
   import vuart_pkg::*;

   logic      rd_q;
   logic      wr_q;
   csr_addr_t addr_q;
   csr_data_t wdata_q;
   logic      hit_dfh;
   logic      hit_uart;
   logic      unmapped_rd_q;   // read that no target answers

   // --------------------
   // request stage
   // --------------------
   always_ff @(posedge clk_csr) begin
      if (!rst_n_csr) begin
         rd_q <= 1'b0;
         wr_q <= 1'b0;
      end else begin
         rd_q <= csr_req.rd;
         wr_q <= csr_req.wr;
      end
   end

   always_ff @(posedge clk_csr) begin
      addr_q  <= csr_req.addr;
      wdata_q <= csr_req.wdata;
   end

   assign hit_dfh  = addr_q < `VUART_UART_BASE;
   assign hit_uart = (addr_q >= `VUART_UART_BASE) && (addr_q < `VUART_UNMAPPED_BASE);

   assign dfh_req  = '{rd: rd_q & hit_dfh, wr: wr_q & hit_dfh,
                       addr: addr_q, wdata: wdata_q};
   assign uart_req = '{rd: rd_q & hit_uart, wr: wr_q & hit_uart,
                       addr: addr_q - `VUART_UART_BASE, wdata: wdata_q};   // offset into uart

   // answer unmapped reads alongside the targets' slot
   always_ff @(posedge clk_csr) begin
      if (!rst_n_csr) begin
         unmapped_rd_q <= 1'b0;
      end else begin
         unmapped_rd_q <= rd_q & ~hit_dfh & ~hit_uart;
      end
   end

   // --------------------
   // response merge
   // --------------------
   assign csr_rsp.valid = dfh_rsp.valid | uart_rsp.valid | unmapped_rd_q;
   assign csr_rsp.rdata = dfh_rsp.valid  ? dfh_rsp.rdata  :
                          uart_rsp.valid ? uart_rsp.rdata : '0;   // zero for unmapped

endmodule

/* src/vuart_dfh_csr.sv */
// header is read only; unlisted offsets read zero and ignore writes
`include "vuart_defines.svh"

module vuart_dfh_csr (
   input  logic                 clk_csr,
   input  logic                 rst_n_csr,
   input  vuart_pkg::csr_req_t  req,
   output vuart_pkg::csr_rsp_t  rsp,
   output vuart_pkg::msg_addr_t msg_addr,
   output vuart_pkg::csr_data_t msg_data
);
   import vuart_pkg::*;

   csr_data_t scratch;
   csr_data_t rd_mux;
   logic      rsp_valid;
   csr_data_t rsp_rdata;

   // --------------------
   // write side
   // --------------------
   always_ff @(posedge clk_csr) begin
      if (!rst_n_csr) begin
         msg_addr <= '0;
         msg_data <= `VUART_MSG_DATA_RESET;
         scratch  <= '0;
      end else if (req.wr) begin
         case (req.addr)
            `VUART_DFH_MSG_ADDR_OFS: msg_addr <= req.wdata[19:0];   // 20-bit target
            `VUART_DFH_MSG_DATA_OFS: msg_data <= req.wdata;
            `VUART_DFH_SCRATCH_OFS:  scratch  <= req.wdata;
            default: ;                                               // header stays fixed
         endcase
      end
   end

   // --------------------
   // read side
   // --------------------
   always_comb begin
      case (req.addr)
         `VUART_DFH_HDR_OFS:      rd_mux = `VUART_DFH_HEADER;
         `VUART_DFH_MSG_ADDR_OFS: rd_mux = {12'd0, msg_addr};
         `VUART_DFH_MSG_DATA_OFS: rd_mux = msg_data;
         `VUART_DFH_SCRATCH_OFS:  rd_mux = scratch;
         default:                 rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk_csr) begin
      if (!rst_n_csr) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= req.rd;
      end
   end

   always_ff @(posedge clk_csr) begin
      if (req.rd) begin
         rsp_rdata <= rd_mux;
      end
   end

   assign rsp = '{valid: rsp_valid, rdata: rsp_rdata};

endmodule

/* src/vuart_uart_core.sv */
// 8N1 only with no parity or FIFO; one byte held each way; divisor must be 2 or more
`include "vuart_defines.svh"

module vuart_uart_core (
   input  logic                clk_csr,
   input  logic                rst_n_csr,
   input  vuart_pkg::csr_req_t req,
   output vuart_pkg::csr_rsp_t rsp,
   output logic                uart_irq,
   output logic                uart_tx,
   input  logic                uart_rx
);
   import vuart_pkg::*;

   baud_div_t  baud_div;
   logic       irq_en_rx;
   logic       irq_en_tx_idle;
   uart_byte_t rx_byte;          // last received character
   logic       rx_valid;
   logic       rx_overrun;
   logic       tx_busy;
   logic       tx_load;          // accepted tx data write
   logic       rd_rxdata;
   logic       rd_status;
   logic       rx_done;          // good stop bit sampled
   logic       rsp_valid;
   csr_data_t  rsp_rdata;
   csr_data_t  rd_mux;

   tx_state_e  tx_state;
   baud_div_t  tx_cnt;
   logic [2:0] tx_bit;
   uart_byte_t tx_shift;
   logic       tx_tick;

   rx_state_e  rx_state;
   baud_div_t  rx_cnt;
   logic [2:0] rx_bit;
   uart_byte_t rx_shift;
   logic       rx_s1;
   logic       rx_s2;
   logic       rx_tick;
   logic       rx_mid;

   assign tx_tick   = tx_cnt == baud_div - 16'd1;
   assign rx_tick   = rx_cnt == baud_div - 16'd1;
   assign rx_mid    = rx_cnt == {1'b0, baud_div[15:1]} - 16'd1;   // half a bit
   assign tx_busy   = tx_state != tx_idle;
   assign tx_load   = req.wr && (req.addr == `VUART_UART_TXDATA_OFS) && !tx_busy;
   assign rd_rxdata = req.rd && (req.addr == `VUART_UART_RXDATA_OFS);
   assign rd_status = req.rd && (req.addr == `VUART_UART_STATUS_OFS);
   assign rx_done   = (rx_state == rx_stop) && rx_tick && rx_s2;

   // --------------------
   // transmit
   // --------------------
   always_ff @(posedge clk_csr) begin
      if (!rst_n_csr) begin
         tx_state <= tx_idle;
         tx_cnt   <= '0;
         tx_bit   <= '0;
      end else begin
         tx_cnt <= (tx_state == tx_idle || tx_tick) ? '0 : tx_cnt + 16'd1;
         case (tx_state)
            tx_idle:  if (tx_load) tx_state <= tx_start;
            tx_start: if (tx_tick) tx_state <= tx_data;
            tx_data: begin
               if (tx_tick) begin
                  tx_bit <= tx_bit + 3'd1;                   // wraps back to 0
                  if (tx_bit == 3'd7) tx_state <= tx_stop;
               end
            end
            tx_stop:  if (tx_tick) tx_state <= tx_idle;
            default:  tx_state <= tx_idle;
         endcase
      end
   end

   always_ff @(posedge clk_csr) begin
      if (tx_load) begin
         tx_shift <= req.wdata[7:0];
      end else if (tx_state == tx_data && tx_tick) begin
         tx_shift <= tx_shift >> 1;   // lsb first
      end
   end

   assign uart_tx = (tx_state == tx_start) ? 1'b0        :
                    (tx_state == tx_data)  ? tx_shift[0] : 1'b1;

   // --------------------
   // receive
   // --------------------
   always_ff @(posedge clk_csr) begin
      if (!rst_n_csr) begin
         rx_s1 <= 1'b1;
         rx_s2 <= 1'b1;
      end else begin
         rx_s1 <= uart_rx;
         rx_s2 <= rx_s1;
      end
   end

   always_ff @(posedge clk_csr) begin
      if (!rst_n_csr) begin
         rx_state <= rx_idle;
         rx_cnt   <= '0;
         rx_bit   <= '0;
      end else begin
         case (rx_state)
            rx_idle: begin
               rx_cnt <= '0;
               if (!rx_s2) rx_state <= rx_start;
            end
            rx_start: begin
               rx_cnt <= rx_mid ? '0 : rx_cnt + 16'd1;
               if (rx_mid) rx_state <= rx_s2 ? rx_idle : rx_data;   // false start drops out
            end
            rx_data: begin
               rx_cnt <= rx_tick ? '0 : rx_cnt + 16'd1;
               if (rx_tick) begin
                  rx_bit <= rx_bit + 3'd1;
                  if (rx_bit == 3'd7) rx_state <= rx_stop;
               end
            end
            rx_stop: begin
               rx_cnt <= rx_tick ? '0 : rx_cnt + 16'd1;
               if (rx_tick) rx_state <= rx_idle;    // framing error just drops the byte
            end
            default: rx_state <= rx_idle;
         endcase
      end
   end

   always_ff @(posedge clk_csr) begin
      if (rx_state == rx_data && rx_tick) begin
         rx_shift <= {rx_s2, rx_shift[7:1]};
      end
   end

   // --------------------
   // registers
   // --------------------
   always_ff @(posedge clk_csr) begin
      if (!rst_n_csr) begin
         baud_div       <= `VUART_BAUD_DIV_RESET;
         irq_en_rx      <= 1'b0;
         irq_en_tx_idle <= 1'b0;
         rx_byte        <= '0;
         rx_valid       <= 1'b0;
         rx_overrun     <= 1'b0;
      end else begin
         if (req.wr && req.addr == `VUART_UART_CTRL_OFS) begin
            irq_en_rx      <= req.wdata[0];
            irq_en_tx_idle <= req.wdata[1];
         end
         if (req.wr && req.addr == `VUART_UART_BAUD_OFS) begin
            baud_div <= req.wdata[15:0];
         end
         if (rd_rxdata) rx_valid <= 1'b0;
         if (rd_status) rx_overrun <= 1'b0;
         if (rx_done) begin                          // new byte wins over read clears
            rx_byte  <= rx_shift;
            rx_valid <= 1'b1;
            if (rx_valid && !rd_rxdata) rx_overrun <= 1'b1;
         end
      end
   end

   always_comb begin
      case (req.addr)
         `VUART_UART_RXDATA_OFS: rd_mux = {24'd0, rx_byte};
         `VUART_UART_STATUS_OFS: rd_mux = {29'd0, rx_overrun, tx_busy, rx_valid};
         `VUART_UART_CTRL_OFS:   rd_mux = {30'd0, irq_en_tx_idle, irq_en_rx};
         `VUART_UART_BAUD_OFS:   rd_mux = {16'd0, baud_div};
         default:                rd_mux = '0;      // tx data is write only
      endcase
   end

   always_ff @(posedge clk_csr) begin
      if (!rst_n_csr) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= req.rd;
      end
   end

   always_ff @(posedge clk_csr) begin
      if (req.rd) begin
         rsp_rdata <= rd_mux;
      end
   end

   assign rsp      = '{valid: rsp_valid, rdata: rsp_rdata};
   assign uart_irq = (rx_valid & irq_en_rx) | (~tx_busy & irq_en_tx_idle);

endmodule

/* src/vuart_irq_msg.sv */
// one message in flight; an irq edge seen while req is high folds into that message
module vuart_irq_msg (
   input  logic                 clk_csr,
   input  logic                 rst_n_csr,
   input  logic                 uart_irq,
   input  vuart_pkg::msg_addr_t msg_addr,
   input  vuart_pkg::csr_data_t msg_data,
   output vuart_pkg::irq_msg_t  irq_msg,
   input  logic                 msg_ack
);
   import vuart_pkg::*;

   logic      irq_d1;
   logic      irq_edge;
   logic      req_q;
   msg_addr_t addr_q;
   csr_data_t data_q;

   assign irq_edge = uart_irq & ~irq_d1;   // rising edge only

   always_ff @(posedge clk_csr) begin
      if (!rst_n_csr) begin
         irq_d1 <= 1'b0;
         req_q  <= 1'b0;
      end else begin
         irq_d1 <= uart_irq;
         if (req_q && msg_ack) begin
            req_q <= 1'b0;
         end else if (irq_edge) begin
            req_q <= 1'b1;
         end
      end
   end

   // fields frozen while the message waits for ack
   always_ff @(posedge clk_csr) begin
      if (irq_edge && !req_q) begin
         addr_q <= msg_addr;
         data_q <= msg_data;
      end
   end

   assign irq_msg = '{req: req_q, addr: addr_q, data: data_q};

endmodule

/* src/vuart_top.sv */
// single clk_csr domain; read data returns two cycles after the strobe for every address
module vuart_top (
   input  logic                clk_csr,
   input  logic                rst_n_csr,
   input  vuart_pkg::csr_req_t csr_req,
   output vuart_pkg::csr_rsp_t csr_rsp,
   output vuart_pkg::irq_msg_t irq_msg,
   input  logic                msg_ack,
   output logic                uart_tx,
   input  logic                uart_rx
);
   import vuart_pkg::*;

   csr_req_t  dfh_req;
   csr_req_t  uart_req;
   csr_rsp_t  dfh_rsp;
   csr_rsp_t  uart_rsp;
   msg_addr_t msg_addr;
   csr_data_t msg_data;
   logic      uart_irq;

   vuart_csr_decode u_decode (
      .clk_csr   (clk_csr),
      .rst_n_csr (rst_n_csr),
      .csr_req   (csr_req),
      .csr_rsp   (csr_rsp),
      .dfh_req   (dfh_req),
      .uart_req  (uart_req),
      .dfh_rsp   (dfh_rsp),
      .uart_rsp  (uart_rsp)
   );

   // feature header and message setup
   vuart_dfh_csr u_dfh (
      .clk_csr   (clk_csr),
      .rst_n_csr (rst_n_csr),
      .req       (dfh_req),
      .rsp       (dfh_rsp),
      .msg_addr  (msg_addr),
      .msg_data  (msg_data)
   );

   vuart_uart_core u_uart (
      .clk_csr   (clk_csr),
      .rst_n_csr (rst_n_csr),
      .req       (uart_req),
      .rsp       (uart_rsp),
      .uart_irq  (uart_irq),
      .uart_tx   (uart_tx),
      .uart_rx   (uart_rx)
   );

   // irq level to in-band message
   vuart_irq_msg u_irq_msg (
      .clk_csr   (clk_csr),
      .rst_n_csr (rst_n_csr),
      .uart_irq  (uart_irq),
      .msg_addr  (msg_addr),
      .msg_data  (msg_data),
      .irq_msg   (irq_msg),
      .msg_ack   (msg_ack)
   );

endmodule

/* testbench/tb_clk_gen.sv */
// 100 ns clock; reset is held low for 8 rising edges and released 5 ns after the last one
module tb_clk_gen (
   output logic clk_csr,
   output logic rst_n_csr
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int half_period  = 50;
   localparam int reset_cycles = 8;

   initial begin
      clk_csr = 1'b0;
      forever #half_period clk_csr = ~clk_csr;
   end

   initial begin
      rst_n_csr = 1'b0;
      repeat (reset_cycles) @(posedge clk_csr);
      #5 rst_n_csr = 1'b1;   // same offset as the stimulus
   end

endmodule

/* testbench/tb_vuart_top.sv */
// uart_tx is looped back to uart_rx; reads expect valid exactly two cycles after the strobe
`include "vuart_defines.svh"

module tb_vuart_top;
   timeunit 1ns;
   timeprecision 100ps;
   import vuart_pkg::*;

   localparam csr_addr_t uart_txdata = `VUART_UART_BASE + `VUART_UART_TXDATA_OFS;
   localparam csr_addr_t uart_rxdata = `VUART_UART_BASE + `VUART_UART_RXDATA_OFS;
   localparam csr_addr_t uart_status = `VUART_UART_BASE + `VUART_UART_STATUS_OFS;
   localparam csr_addr_t uart_ctrl   = `VUART_UART_BASE + `VUART_UART_CTRL_OFS;
   localparam csr_addr_t uart_baud   = `VUART_UART_BASE + `VUART_UART_BAUD_OFS;
   localparam int test_div       = 8;
   localparam int access_count   = 50;
   localparam int access_cycles  = 4;
   localparam int frame_count    = 4;
   localparam int irq_wait_limit = 20 * test_div;   // two frames
   // accesses plus frames at the test divisor, with reset and ack slack, doubled
   localparam int watchdog_ns = 2 * 100 *
      (access_count * access_cycles + frame_count * 10 * test_div + 8 + 10);

   typedef struct packed {
      msg_addr_t  msg_addr;
      csr_data_t  msg_data;
      csr_data_t  scratch;
      logic [1:0] ctrl;
      baud_div_t  baud;
      uart_byte_t rx_byte;
      logic       rx_valid;
      logic       tx_busy;
      logic       rx_overrun;
   } shadow_t;

   typedef struct packed {
      logic      chk;       // compare rdata or just consume the response
      csr_addr_t addr;
      csr_data_t data;
   } pending_t;

   logic     clk_csr;
   logic     rst_n_csr;
   csr_req_t csr_req;
   csr_rsp_t csr_rsp;
   irq_msg_t irq_msg;
   logic     msg_ack;
   logic     uart_loop;             // tx wired straight to rx
   shadow_t  shadow;
   pending_t pending_q[$];
   pending_t cmp_entry;
   integer   seed = 32'haf5b_f85c;
   int       value_errors;
   int       protocol_errors;

   tb_clk_gen u_clk_gen (
      .clk_csr   (clk_csr),
      .rst_n_csr (rst_n_csr)
   );

   vuart_top DUT (
      .clk_csr   (clk_csr),
      .rst_n_csr (rst_n_csr),
      .csr_req   (csr_req),
      .csr_rsp   (csr_rsp),
      .irq_msg   (irq_msg),
      .msg_ack   (msg_ack),
      .uart_tx   (uart_loop),
      .uart_rx   (uart_loop)
   );

   // --------------------
   // register model
   // --------------------
   function automatic csr_data_t expected_read(input csr_addr_t addr, input shadow_t sh);
      case (addr)
         `VUART_DFH_HDR_OFS:      return `VUART_DFH_HEADER;
         `VUART_DFH_MSG_ADDR_OFS: return {12'd0, sh.msg_addr};
         `VUART_DFH_MSG_DATA_OFS: return sh.msg_data;
         `VUART_DFH_SCRATCH_OFS:  return sh.scratch;
         uart_rxdata:             return {24'd0, sh.rx_byte};
         uart_status:             return {29'd0, sh.rx_overrun, sh.tx_busy, sh.rx_valid};
         uart_ctrl:               return {30'd0, sh.ctrl};
         uart_baud:               return {16'd0, sh.baud};
         default:                 return '0;   // tx data, gaps and unmapped space
      endcase
   endfunction

   task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
      @(posedge clk_csr);
      #5;
      csr_req = '{rd: 1'b0, wr: 1'b1, addr: addr, wdata: data};
      @(posedge clk_csr);
      #5;
      csr_req.wr = 1'b0;
      case (addr)
         `VUART_DFH_MSG_ADDR_OFS: shadow.msg_addr = data[19:0];
         `VUART_DFH_MSG_DATA_OFS: shadow.msg_data = data;
         `VUART_DFH_SCRATCH_OFS:  shadow.scratch  = data;
         uart_ctrl:               shadow.ctrl     = data[1:0];
         uart_baud:               shadow.baud     = data[15:0];
         default: ;                                 // header and tx data leave no state
      endcase
   endtask

   task automatic csr_read(input csr_addr_t addr, input logic check, output csr_data_t data);
      pending_t entry;
      entry = '{chk: check, addr: addr, data: expected_read(addr, shadow)};
      pending_q.push_back(entry);
      if (addr == uart_rxdata) shadow.rx_valid = 1'b0;     // read side effects
      if (addr == uart_status) shadow.rx_overrun = 1'b0;
      @(posedge clk_csr);
      #5;
      csr_req = '{rd: 1'b1, wr: 1'b0, addr: addr, wdata: '0};
      @(posedge clk_csr);
      #5;
      csr_req.rd = 1'b0;
      @(posedge clk_csr);
      @(negedge clk_csr);                                  // middle of cycle N+2
      data = csr_rsp.rdata;
      if (!csr_rsp.valid) begin
         protocol_errors++;
         $display("no read response two cycles after the read of address %h", addr);
         void'(pending_q.pop_front());
      end
   endtask

   task automatic check_read(input csr_addr_t addr);
      csr_data_t unused;
      csr_read(addr, 1'b1, unused);
   endtask

   task automatic poll_status(input logic [2:0] mask, input logic [2:0] value,
                              output csr_data_t st);
      st = '0;
      do begin
         csr_read(uart_status, 1'b0, st);
      end while ((st[2:0] & mask) != value);
   endtask

   // --------------------
   // response compare
   // --------------------
   always @(negedge clk_csr) begin
      if (rst_n_csr && csr_rsp.valid) begin
         if (pending_q.size() == 0) begin
            protocol_errors++;
            $display("read response arrived with no read outstanding");
         end else begin
            cmp_entry = pending_q.pop_front();
            if (cmp_entry.chk && csr_rsp.rdata !== cmp_entry.data) begin
               value_errors++;
               $display("[FAIL] csr_rsp.rdata at %h expected %h actual %h",
                        cmp_entry.addr, cmp_entry.data, csr_rsp.rdata);
            end
         end
      end
   end

   initial begin
      #watchdog_ns;
      $display("watchdog expired after %0d ns with tests still running", watchdog_ns);
      $display("*** FAILED ***");
      $finish;
   end

   initial begin : run_tests
      csr_data_t  rnd;
      csr_data_t  st;
      uart_byte_t tx_byte;
      irq_msg_t   held;
      int         ack_wait;
      int         waited;
      csr_req = '0;
      msg_ack = 1'b0;
      value_errors = 0;
      protocol_errors = 0;
      shadow = '0;
      shadow.msg_data = `VUART_MSG_DATA_RESET;
      shadow.baud = `VUART_BAUD_DIV_RESET;
      @(posedge rst_n_csr);
      @(negedge clk_csr);

      // reset values
      if (csr_rsp.valid !== 1'b0) begin
         value_errors++;
         $display("[FAIL] csr_rsp.valid expected 0 actual %h", csr_rsp.valid);
      end
      if (irq_msg.req !== 1'b0) begin
         value_errors++;
         $display("[FAIL] irq_msg.req expected 0 actual %h", irq_msg.req);
      end
      if (uart_loop !== 1'b1) begin
         value_errors++;
         $display("[FAIL] uart_tx expected 1 actual %h", uart_loop);
      end
      check_read(`VUART_DFH_HDR_OFS);
      check_read(`VUART_DFH_MSG_ADDR_OFS);
      check_read(`VUART_DFH_MSG_DATA_OFS);
      check_read(`VUART_DFH_SCRATCH_OFS);
      check_read(uart_rxdata);
      check_read(uart_status);
      check_read(uart_ctrl);
      check_read(uart_baud);

      // dfh read back and a header write that must not stick
      repeat (2) begin
         rnd = $random(seed);
         csr_write(`VUART_DFH_MSG_ADDR_OFS, rnd);
         rnd = $random(seed);
         csr_write(`VUART_DFH_MSG_DATA_OFS, rnd);
         rnd = $random(seed);
         csr_write(`VUART_DFH_SCRATCH_OFS, rnd);
         rnd = $random(seed);
         csr_write(`VUART_DFH_HDR_OFS, rnd);
         check_read(`VUART_DFH_HDR_OFS);
         check_read(`VUART_DFH_MSG_ADDR_OFS);
         check_read(`VUART_DFH_MSG_DATA_OFS);
         check_read(`VUART_DFH_SCRATCH_OFS);
      end

      // unmapped space and gaps
      rnd = $random(seed);
      check_read(`VUART_UNMAPPED_BASE);
      check_read({2'b01, rnd[9:0]});
      check_read(12'hfff);
      check_read(12'h004);
      check_read(12'h1fc);
      check_read(uart_txdata);
      check_read(`VUART_UART_BASE + 12'h014);

      // loopback at divisor 8
      csr_write(uart_baud, test_div);
      check_read(uart_baud);
      rnd = $random(seed);
      tx_byte = rnd[7:0];
      csr_write(uart_txdata, {24'd0, tx_byte});
      poll_status(3'b011, 3'b001, st);
      shadow.rx_byte = tx_byte;
      shadow.rx_valid = 1'b1;
      check_read(uart_status);
      check_read(uart_rxdata);
      check_read(uart_status);

      // --------------------
      // interrupt message
      // --------------------
      csr_write(uart_ctrl, 32'h1);
      rnd = $random(seed);
      csr_write(`VUART_DFH_MSG_ADDR_OFS, rnd);
      rnd = $random(seed);
      csr_write(`VUART_DFH_MSG_DATA_OFS, rnd);
      rnd = $random(seed);
      tx_byte = rnd[7:0];
      csr_write(uart_txdata, {24'd0, tx_byte});
      waited = 0;
      while (irq_msg.req !== 1'b1 && waited < irq_wait_limit) begin
         @(negedge clk_csr);
         waited++;
      end
      if (irq_msg.req !== 1'b1) begin
         protocol_errors++;
         $display("no interrupt message after the looped-back byte");
      end else begin
         if (irq_msg.addr !== shadow.msg_addr) begin
            value_errors++;
            $display("[FAIL] irq_msg.addr expected %h actual %h", shadow.msg_addr, irq_msg.addr);
         end
         if (irq_msg.data !== shadow.msg_data) begin
            value_errors++;
            $display("[FAIL] irq_msg.data expected %h actual %h", shadow.msg_data, irq_msg.data);
         end
         held = irq_msg;
         ack_wait = 1 + ({$random(seed)} % 10);
         repeat (ack_wait) begin
            @(negedge clk_csr);
            if (irq_msg !== held) begin
               value_errors++;
               $display("[FAIL] irq_msg expected %h actual %h", held, irq_msg);
            end
         end
         @(posedge clk_csr);
         #5;
         msg_ack = 1'b1;
         @(posedge clk_csr);                   // edge that samples ack
         #5;
         msg_ack = 1'b0;
         if (irq_msg.req !== 1'b0) begin
            value_errors++;
            $display("[FAIL] irq_msg.req expected 0 actual %h", irq_msg.req);
         end
      end
      shadow.rx_byte = tx_byte;
      shadow.rx_valid = 1'b1;
      check_read(uart_rxdata);
      csr_write(uart_ctrl, 32'h0);

      // overrun where the second byte replaces the first
      poll_status(3'b010, 3'b000, st);
      rnd = $random(seed);
      tx_byte = rnd[7:0];
      csr_write(uart_txdata, {24'd0, tx_byte});
      poll_status(3'b011, 3'b001, st);
      rnd = $random(seed);
      tx_byte = rnd[7:0];
      csr_write(uart_txdata, {24'd0, tx_byte});
      poll_status(3'b100, 3'b100, st);
      if (st[0] !== 1'b1) begin
         value_errors++;
         $display("[FAIL] status.rx_valid expected 1 actual %h", st[0]);
      end
      poll_status(3'b010, 3'b000, st);
      shadow.rx_byte = tx_byte;
      shadow.rx_valid = 1'b1;
      check_read(uart_status);
      check_read(uart_rxdata);

      repeat (2) @(negedge clk_csr);           // let the last compare run
      $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
      if (value_errors + protocol_errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

/* files.f */
+incdir+include
src/vuart_pkg.sv
src/vuart_csr_decode.sv
src/vuart_dfh_csr.sv
src/vuart_uart_core.sv
src/vuart_irq_msg.sv
src/vuart_top.sv
testbench/tb_clk_gen.sv
testbench/tb_vuart_top.sv
